// File: src/cart_pkg.sv
// Only carts 0, 5, 19, 32 and 33 are modelled; RAM banks use 3 bits, ROM banks 7 bits, 64 table entries

package cart_pkg;

	// ******************************
	// Sizes and address constants
	// ******************************
	localparam int          TABLE_DEPTH  = 64;        // Bank table entries
	localparam logic [15:0] BANK_8K      = 16'h2000;  // Larger packets fill lo and hi
	localparam logic [15:0] LADDR_ROMH   = 16'h8000;  // Above this a packet goes to hi only
	localparam int          ROM_BASE_BIT = 20;        // ROM banks live at 0x100000
	localparam logic [4:0]  RAM_BASE     = 5'b00100;  // Bits 20..16 of 0x040000

	typedef logic [6:0] bank_t;

	// CRT hardware type ids
	typedef enum logic [15:0] {
		GENERIC     = 16'd0,
		OCEAN       = 16'd5,
		MAGIC_DESK  = 16'd19,
		EASYFLASH   = 16'd32,
		EASYFLASH_X = 16'd33
	} cart_id_e;

	// ******************************
	// Bus structs
	// ******************************
	typedef struct packed {
		bank_t lo;
		bank_t hi;
	} bank_pair_t;

	// One CHIP packet of the CRT file
	typedef struct packed {
		logic [15:0] laddr;     // Load address
		logic [15:0] size;      // Packet length
		logic [15:0] num;       // Bank number
		logic [24:0] raddr;     // Packet location in SDRAM
	} bank_load_t;

	typedef struct packed {
		logic       wr;
		logic [5:0] index;
		bank_t      lo;
		bank_t      hi;
		logic       lo_vld;     // Write lo half
		logic       hi_vld;     // Write hi half
	} table_wr_t;

	typedef struct packed {
		logic [17:0] addr;
		logic [7:0]  data;
		logic        write;
		logic        mem_ce;
		logic        romL;
		logic        romH;
		logic        IOE;
		logic        IOF;
	} cpu_bus_t;

	// Registered mapper output
	typedef struct packed {
		bank_t bank_lo;
		bank_t bank_hi;
		bank_t ioe_bank;
		bank_t iof_bank;
		logic  ioe_ena;
		logic  iof_ena;
		logic  ioe_wr_ena;
		logic  iof_wr_ena;
		logic  roml_we;         // ROML maps to RAM and is writable
		logic  exrom;
		logic  game;
	} map_state_t;

endpackage

// File: src/bank_loader.sv
// Packets with num of 64 or more are counted but not stored; bank_cnt wraps at 256
`timescale 1ns/1ps

module bank_loader import cart_pkg::*; (
	input  logic       clk32,
	input  logic       reset_n,
	input  logic       cart_loading,
	input  logic       cart_bank_wr,
	input  bank_load_t cart_bank,
	output table_wr_t  table_wr,
	output logic [7:0] bank_cnt
);

	logic  old_loading;
	logic  low_half;       // Packet starts in the ROML window
	bank_t raddr_bank;

	assign raddr_bank = cart_bank.raddr[19:13];
	assign low_half   = (cart_bank.laddr <= LADDR_ROMH);

	// Table write goes out in the same cycle as the packet strobe
	always_comb begin
		table_wr.wr     = cart_bank_wr && (cart_bank.num < TABLE_DEPTH);
		table_wr.index  = cart_bank.num[5:0];
		table_wr.lo     = raddr_bank;
		table_wr.lo_vld = low_half;
		if (low_half) begin
			table_wr.hi     = raddr_bank + 7'd1;     // 16K packet, upper half follows
			table_wr.hi_vld = (cart_bank.size > BANK_8K);
		end else begin
			table_wr.hi     = raddr_bank;
			table_wr.hi_vld = 1'b1;
		end
	end

	// ******************************
	// Packet counter
	// ******************************
	always_ff @(posedge clk32) begin
		if (reset_n) begin
			old_loading <= 1'b0;
			bank_cnt    <= 8'd0;
		end else begin
			old_loading <= cart_loading;
			if (cart_loading && !old_loading)
				bank_cnt <= 8'd0;               // New file starts
			if (cart_bank_wr)
				bank_cnt <= bank_cnt + 8'd1;    // Strobe wins over restart
		end
	end

endmodule

// File: src/bank_table.sv
// Entries hold no reset value; read is asynchronous so a write shows after its clock edge
`timescale 1ns/1ps

module bank_table import cart_pkg::*; (
	input  logic       clk32,
	input  table_wr_t  table_wr,
	input  logic [5:0] rd_index,
	output bank_pair_t rd_entry
);

	bank_t lo_banks [TABLE_DEPTH];   // ROML bank per entry
	bank_t hi_banks [TABLE_DEPTH];   // ROMH bank per entry

	always_ff @(posedge clk32) begin
		if (table_wr.wr) begin
			if (table_wr.lo_vld)
				lo_banks[table_wr.index] <= table_wr.lo;
			if (table_wr.hi_vld)
				hi_banks[table_wr.index] <= table_wr.hi;
		end
	end

	// Read port
	assign rd_entry.lo = lo_banks[rd_index];
	assign rd_entry.hi = hi_banks[rd_index];

endmodule

// File: src/bank_mapper.sv
// Unknown cart ids keep the cleared state; only IOE writes change banks, IOF is never decoded
`timescale 1ns/1ps

module bank_mapper import cart_pkg::*; (
	input  logic       clk32,
	input  logic       reset_n,
	input  cart_id_e   cart_id,
	input  logic [7:0] cart_exrom,
	input  logic [7:0] cart_game,
	input  cpu_bus_t   cpu,
	input  logic [7:0] bank_cnt,
	input  bank_pair_t rd_entry,
	output logic [5:0] rd_index,
	output map_state_t state,
	output logic       ioe_stb,
	output logic       iof_stb
);

	logic     old_ioe;
	logic     old_iof;
	logic     init;       // High for one cycle after a clear
	logic     ioe_wr;
	logic     is_ef;
	cart_id_e old_id;

	// ******************************
	// IO edge detection
	// ******************************
	always_ff @(posedge clk32) begin
		if (reset_n) begin
			old_ioe <= 1'b0;
			old_iof <= 1'b0;
		end else begin
			old_ioe <= cpu.IOE;
			old_iof <= cpu.IOF;
		end
	end

	assign ioe_stb = cpu.IOE & ~old_ioe;
	assign iof_stb = cpu.IOF & ~old_iof;
	assign ioe_wr  = ioe_stb & cpu.write;

	assign is_ef = (cart_id == EASYFLASH) || (cart_id == EASYFLASH_X);

	// EasyFlash bank write looks up the table, everything else reads entry 0
	always_comb begin
		rd_index = 6'd0;
		if (is_ef && ioe_wr && !cpu.addr[1])
			rd_index = cpu.data[5:0];
	end

	always_ff @(posedge clk32) begin
		old_id <= cart_id;
	end

	// ******************************
	// Per-cart registers
	// ******************************
	always_ff @(posedge clk32) begin
		if (reset_n || (old_id != cart_id)) begin
			state       <= '0;
			state.exrom <= 1'b1;     // Cart invisible until it sets up
			state.game  <= 1'b1;
			init        <= 1'b1;
		end else begin
			init <= 1'b0;
			case (cart_id)
				GENERIC: begin
					state.exrom   <= cart_exrom[0];
					state.game    <= cart_game[0];
					state.bank_lo <= rd_entry.lo;
					state.bank_hi <= rd_entry.hi;
				end

				// Bank number in DE00 bits 5..0, mirrored to both windows
				OCEAN: begin
					state.exrom <= 1'b0;
					state.game  <= 1'b0;
					if (ioe_wr) begin
						state.bank_lo <= {1'b0, cpu.data[5:0]};
						state.bank_hi <= {1'b0, cpu.data[5:0]};
					end
				end

				MAGIC_DESK: begin
					if (init) begin
						state.game    <= 1'b1;
						state.exrom   <= 1'b0;
						state.bank_lo <= 7'd0;
					end
					if (ioe_wr) begin
						if (bank_cnt <= 8'd16)
							state.bank_lo <= {3'b000, cpu.data[3:0]};
						else if (bank_cnt <= 8'd32)
							state.bank_lo <= {2'b00, cpu.data[4:0]};
						else if (bank_cnt <= 8'd64)
							state.bank_lo <= {1'b0, cpu.data[5:0]};
						else
							state.bank_lo <= cpu.data[6:0];
						state.exrom <= cpu.data[7];   // Bit 7 hides the cart
					end
				end

				EASYFLASH, EASYFLASH_X: begin
					if (init) begin
						state.iof_bank   <= 7'd0;       // 256 bytes of RAM at DFxx
						state.iof_ena    <= 1'b1;
						state.iof_wr_ena <= 1'b1;
						state.exrom      <= (cart_id == EASYFLASH_X);   // Id 33 boots ultimax
						state.game       <= 1'b0;
						state.bank_lo    <= rd_entry.lo;
						state.bank_hi    <= rd_entry.hi;
					end
					if (ioe_wr) begin
						if (cpu.addr[1]) begin
							// DE02 control, boot jumper assumed open
							state.game  <= ~cpu.data[0] & cpu.data[2];
							state.exrom <= ~cpu.data[1];
						end else begin
							state.bank_lo <= rd_entry.lo;
							state.bank_hi <= rd_entry.hi;
						end
					end
				end

				default: ;
			endcase
		end
	end

endmodule

// File: src/addr_translate.sv
// Purely combinational; addresses above bit 20 stay 0, ROMH is never mapped to RAM
`timescale 1ns/1ps

module addr_translate import cart_pkg::*; (
	input  cpu_bus_t    cpu,
	input  map_state_t  state,
	input  logic        ioe_stb,
	input  logic        iof_stb,
	output logic [24:0] addr_out,
	output logic        mem_write_out,
	output logic        mem_ce_out,
	output logic        IO_rom
);

	logic cs_ioe;
	logic cs_iof;

	// Bits 20..13 of the SDRAM address for a bank
	function automatic logic [7:0] region(input bank_t bank, input logic ram);
		logic [7:0] r;
		if (ram) begin
			r = {RAM_BASE, bank[2:0]};      // 64K of RAM at 0x040000
		end else begin
			r = {1'b0, bank};
			r[ROM_BASE_BIT - 13] = 1'b1;    // 1MB of ROM at 0x100000
		end
		return r;
	endfunction

	// IO page selected for this access direction
	assign cs_ioe = cpu.IOE && (cpu.write ? state.ioe_wr_ena : state.ioe_ena);
	assign cs_iof = cpu.IOF && (cpu.write ? state.iof_wr_ena : state.iof_ena);

	assign mem_ce_out = cpu.mem_ce | (cs_ioe & ioe_stb) | (cs_iof & iof_stb);
	assign IO_rom     = (cpu.IOE & state.ioe_ena) | (cpu.IOF & state.iof_ena);

	// ******************************
	// Address and write gating
	// ******************************
	always_comb begin
		// No RAM under ROML in ultimax, so writes there are dropped
		mem_write_out = cpu.write &
			~(cpu.romL & ~state.roml_we & state.exrom & ~state.game);

		addr_out = {7'd0, cpu.addr};

		if (cpu.romH && !cpu.write)
			addr_out[24:13] = {4'd0, region(state.bank_hi, 1'b0)};
		if (cpu.romL && (state.roml_we || !cpu.write))
			addr_out[24:13] = {4'd0, region(state.bank_lo, state.roml_we)};

		if (cs_ioe)
			addr_out[24:13] = {4'd0, region(state.ioe_bank, state.ioe_wr_ena)};   // DExx
		if (cs_iof)
			addr_out[24:13] = {4'd0, region(state.iof_bank, state.iof_wr_ena)};   // DFxx
	end

endmodule

// File: src/cartridge_top.sv
// C64 mode only, no freezers or register readback; the CRT must be loaded before the cart is used
`timescale 1ns/1ps

module cartridge_top import cart_pkg::*; (
	input  logic        clk32,
	input  logic        reset_n,
	input  cart_id_e    cart_id,
	input  logic [7:0]  cart_exrom,
	input  logic [7:0]  cart_game,
	input  logic        cart_loading,
	input  logic        cart_bank_wr,
	input  bank_load_t  cart_bank,
	input  cpu_bus_t    cpu,
	output logic        exrom,
	output logic        game,
	output logic        mem_ce_out,
	output logic        mem_write_out,
	output logic        IO_rom,
	output logic [24:0] addr_out
);

	table_wr_t  table_wr;
	bank_pair_t rd_entry;
	map_state_t state;
	logic [7:0] bank_cnt;
	logic [5:0] rd_index;
	logic       ioe_stb;
	logic       iof_stb;

	assign exrom = state.exrom;    // Lines come straight from the mapper
	assign game  = state.game;

	bank_loader u_loader (
		.clk32        (clk32),
		.reset_n      (reset_n),
		.cart_loading (cart_loading),
		.cart_bank_wr (cart_bank_wr),
		.cart_bank    (cart_bank),
		.table_wr     (table_wr),
		.bank_cnt     (bank_cnt)
	);

	bank_table u_table (
		.clk32    (clk32),
		.table_wr (table_wr),
		.rd_index (rd_index),
		.rd_entry (rd_entry)
	);

	bank_mapper u_mapper (
		.clk32      (clk32),
		.reset_n    (reset_n),
		.cart_id    (cart_id),
		.cart_exrom (cart_exrom),
		.cart_game  (cart_game),
		.cpu        (cpu),
		.bank_cnt   (bank_cnt),
		.rd_entry   (rd_entry),
		.rd_index   (rd_index),
		.state      (state),
		.ioe_stb    (ioe_stb),
		.iof_stb    (iof_stb)
	);

	addr_translate u_translate (
		.cpu           (cpu),
		.state         (state),
		.ioe_stb       (ioe_stb),
		.iof_stb       (iof_stb),
		.addr_out      (addr_out),
		.mem_write_out (mem_write_out),
		.mem_ce_out    (mem_ce_out),
		.IO_rom        (IO_rom)
	);

endmodule

// File: testbench/cartridge_checker.sv
// Sampled on clk32 at the top level; counts its own assertion failures in fails
`timescale 1ns/1ps

module cartridge_checker import cart_pkg::*; (
	input logic     clk32,
	input logic     reset_n,
	input logic     exrom,
	input logic     game,
	input cpu_bus_t cpu,
	input logic     ioe_stb,
	input logic     iof_stb,
	input logic     mem_ce_out,
	input logic     mem_write_out
);

	int fails = 0;    // Assertion failures so far

	lines_after_reset: assert property (@(posedge clk32) reset_n |=> (exrom && game))
		else begin
			$error("exrom or game low in the cycle after reset");
			fails++;
		end

	// Chip enable only from the CPU or an IO strobe
	ce_source: assert property (@(posedge clk32)
		$rose(mem_ce_out) |-> (cpu.mem_ce || ioe_stb || iof_stb))
		else begin
			$error("mem_ce_out rose without mem_ce or an IO strobe");
			fails++;
		end

	write_needs_cpu: assert property (@(posedge clk32) mem_write_out |-> cpu.write)
		else begin
			$error("mem_write_out high while the CPU does not write");
			fails++;
		end

endmodule

// Mapper lines and translator outputs are all visible at the top level
bind cartridge_top cartridge_checker u_check (.*);

// File: testbench/cart_monitor.sv
// Reference model of bank table, bank count and mapper registers; compares only while check is high
`timescale 1ns/1ps

module cart_monitor import cart_pkg::*; (
	input  logic        clk32, reset_n, cart_loading, cart_bank_wr,
	input  cart_id_e    cart_id,
	input  logic [7:0]  cart_exrom, cart_game,
	input  bank_load_t  cart_bank,
	input  cpu_bus_t    cpu,
	input  logic        check, test_done,
	input  logic [2:0]  test_num,
	input  logic        exrom, game, mem_ce_out, mem_write_out, IO_rom,
	input  logic [24:0] addr_out,
	output int          checks, errors
);

	bank_t       tbl_lo [TABLE_DEPTH];    // Model of the bank table
	bank_t       tbl_hi [TABLE_DEPTH];
	bank_t       m_lo, m_hi;
	logic        m_exrom, m_game, m_init;
	logic        m_iof;                   // IOF RAM page on
	logic [7:0]  m_cnt;
	logic        old_ioe, old_iof, old_load;
	logic        ioe_wr;
	cart_id_e    prev_id;
	logic        exp_wr, exp_ce;
	logic [24:0] exp_addr;
	int          test_checks = 0;
	int          test_errors = 0;

	assign ioe_wr = cpu.IOE & ~old_ioe & cpu.write;

	// ROM at 0x100000 + bank * 8K, the IOF page at RAM bank 0 of 0x040000
	function automatic logic [24:0] expected_addr(input cpu_bus_t b, input bank_t lo,
			input bank_t hi, input logic iof_on);
		logic [24:0] a;
		a = {7'd0, b.addr};
		if (b.romH && !b.write)
			a[24:13] = {4'd0, 1'b1, hi};
		if (b.romL && !b.write)
			a[24:13] = {4'd0, 1'b1, lo};
		if (b.IOF && iof_on)
			a[24:13] = 12'h020;
		return a;
	endfunction

	function automatic bank_t magic_bank(input logic [7:0] d, input logic [7:0] cnt);
		if (cnt <= 8'd16)
			return {3'd0, d[3:0]};
		if (cnt <= 8'd32)
			return {2'd0, d[4:0]};
		if (cnt <= 8'd64)
			return {1'd0, d[5:0]};
		return d[6:0];
	endfunction

	task automatic compare(input string what, input logic [24:0] got, input logic [24:0] exp);
		checks++;
		test_checks++;
		if (got !== exp) begin
			errors++;
			test_errors++;
			$display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	initial begin
		checks = 0;
		errors = 0;
	end

	// ******************************
	// Model update
	// ******************************
	always @(posedge clk32) begin
		old_ioe  <= cpu.IOE;
		old_iof  <= cpu.IOF;
		old_load <= reset_n ? 1'b0 : cart_loading;
		prev_id  <= cart_id;
		if (cart_bank_wr && cart_bank.num < 16'd64) begin
			if (cart_bank.laddr <= 16'h8000) begin
				tbl_lo[cart_bank.num[5:0]] <= cart_bank.raddr[19:13];
				if (cart_bank.size > 16'h2000)   // 16K packet fills both halves
					tbl_hi[cart_bank.num[5:0]] <= cart_bank.raddr[19:13] + 7'd1;
			end else begin
				tbl_hi[cart_bank.num[5:0]] <= cart_bank.raddr[19:13];
			end
		end
		if (reset_n)
			m_cnt <= 8'd0;
		else if (cart_bank_wr)
			m_cnt <= m_cnt + 8'd1;
		else if (cart_loading && !old_load)
			m_cnt <= 8'd0;

		if (reset_n || cart_id != prev_id) begin
			{m_lo, m_hi, m_iof} <= '0;
			{m_exrom, m_game, m_init} <= 3'b111;
		end else begin
			m_init <= 1'b0;
			case (cart_id)
				GENERIC: begin
					{m_exrom, m_game} <= {cart_exrom[0], cart_game[0]};
					{m_lo, m_hi} <= {tbl_lo[0], tbl_hi[0]};
				end
				OCEAN: begin
					{m_exrom, m_game} <= 2'b00;
					if (ioe_wr)
						{m_lo, m_hi} <= {2{1'b0, cpu.data[5:0]}};
				end
				MAGIC_DESK: begin
					if (m_init)
						{m_exrom, m_game} <= 2'b01;
					if (ioe_wr)
						{m_exrom, m_lo} <= {cpu.data[7], magic_bank(cpu.data, m_cnt)};
				end
				EASYFLASH, EASYFLASH_X: begin
					if (m_init) begin
						{m_exrom, m_game, m_iof} <= {cart_id == EASYFLASH_X, 2'b01};
						{m_lo, m_hi} <= {tbl_lo[0], tbl_hi[0]};
					end
					if (ioe_wr && cpu.addr[1])   // Control register
						{m_game, m_exrom} <= {~cpu.data[0] & cpu.data[2], ~cpu.data[1]};
					else if (ioe_wr)
						{m_lo, m_hi} <= {tbl_lo[cpu.data[5:0]], tbl_hi[cpu.data[5:0]]};
				end
				default: ;
			endcase
		end
	end

	// Outputs are settled half a cycle after the inputs change
	always @(negedge clk32) begin
		if (check) begin
			exp_addr = expected_addr(cpu, m_lo, m_hi, m_iof);
			exp_wr   = cpu.write & ~(cpu.romL & m_exrom & ~m_game);   // Ultimax ROML
			exp_ce   = cpu.mem_ce | (cpu.IOF & ~old_iof & m_iof);
			compare("addr_out", addr_out, exp_addr);
			compare("exrom", exrom, m_exrom);
			compare("game", game, m_game);
			compare("mem_write_out", mem_write_out, exp_wr);
			compare("mem_ce_out", mem_ce_out, exp_ce);
			compare("IO_rom", IO_rom, cpu.IOF & m_iof);
		end
		if (test_done) begin
			$display("Test %0d finished: %0d checks, %0d errors", test_num, test_checks,
				test_errors);
			test_checks = 0;
			test_errors = 0;
		end
	end

endmodule

// File: testbench/cartridge_tb.sv
// Inputs change 1 ns after the rising edge; the run stops at 40 cycles per planned access
`timescale 1ns/1ps

module cartridge_tb import cart_pkg::*; ();

	localparam int RESET_CYCLES = 8;
	// Accesses per test: generic, ocean, magic desk, easyflash, protection
	localparam int ACCESSES     = 13 + 12 + 166 + 41 + 3;
	localparam int CYCLE_LIMIT  = ACCESSES * 40 + RESET_CYCLES;

	logic        clk32, reset_n, cart_loading, cart_bank_wr;
	logic        exrom, game, mem_ce_out, mem_write_out, IO_rom;
	logic        check, test_done;
	logic [2:0]  test_num;
	logic [7:0]  cart_exrom, cart_game;
	logic [24:0] addr_out;
	logic [31:0] rng;
	cart_id_e    cart_id;
	bank_load_t  cart_bank;
	cpu_bus_t    cpu;
	int          checks, errors;
	int          cycles = 0;
	int          sizes [3] = '{16, 32, 100};    // Magic Desk file lengths

	cartridge_top DUT (.*);
	cart_monitor monitor (.*);

	initial begin
		clk32 = 1'b0;
		forever #50 clk32 = ~clk32;
	end

	always @(posedge clk32) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Testbench failed");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	task automatic next_cycle();
		@(posedge clk32);
		#1;
	endtask

	task automatic load_packet(input int num, input logic [15:0] laddr,
			input logic [15:0] size, input bank_t bank);
		cart_bank    = '{laddr: laddr, size: size, num: 16'(num), raddr: {5'd1, bank, 13'd0}};
		cart_bank_wr = 1'b1;
		next_cycle();
		cart_bank_wr = 1'b0;
	endtask

	task automatic start_load();
		cart_loading = 1'b0;
		next_cycle();
		cart_loading = 1'b1;    // Rising edge restarts the bank count
		next_cycle();
	endtask

	// sel is {romL, romH, IOE, IOF}; ROM accesses carry mem_ce, IO ones rely on the strobe
	task automatic access(input logic [3:0] sel, input logic wr, input logic [7:0] data,
			input logic [17:0] addr);
		cpu.addr   = addr;
		cpu.data   = data;
		cpu.write  = wr;
		cpu.mem_ce = sel[3] | sel[2];
		{cpu.romL, cpu.romH, cpu.IOE, cpu.IOF} = sel;
		check = 1'b1;
		next_cycle();
		cpu   = '0;
		check = 1'b0;
		next_cycle();
	endtask

	task automatic rom_reads();
		rng = xorshift(rng);
		access(4'b1000, 1'b0, 8'h00, rng[17:0]);
		access(4'b0100, 1'b0, 8'h00, rng[31:14]);
	endtask

	task automatic set_cart(input cart_id_e id);
		cart_id = id;
		next_cycle();    // Clear
		next_cycle();    // Init
	endtask

	task automatic finish_test(input logic [2:0] n);
		test_num  = n;
		test_done = 1'b1;
		next_cycle();
		test_done = 1'b0;
	endtask

	initial begin
		rng          = 32'd66;
		reset_n      = 1'b1;
		cart_id      = GENERIC;
		{cart_exrom, cart_game} = '0;
		{cart_loading, cart_bank_wr, check, test_done} = '0;
		test_num     = '0;
		cart_bank    = '0;
		cpu          = '0;
		repeat (RESET_CYCLES) @(posedge clk32);
		#1 reset_n = 1'b0;

		// ******************************
		// Generic, ocean, magic desk
		// ******************************
		rng = xorshift(rng);
		{cart_exrom, cart_game} = rng[15:0];
		start_load();
		load_packet(0, 16'h8000, 16'h4000, rng[22:16]);
		for (int i = 1; i < 8; i++) begin
			rng = xorshift(rng);
			load_packet(i, rng[0] ? 16'hA000 : 16'h8000, rng[1] ? 16'h4000 : 16'h2000, rng[8:2]);
		end
		load_packet(0, 16'hA000, 16'h2000, rng[15:9]);    // ROMH of entry 0 alone
		cart_loading = 1'b0;
		rom_reads();
		{cart_exrom, cart_game} = rng[31:16];
		rom_reads();
		finish_test(1);

		set_cart(OCEAN);
		repeat (4) begin
			rng = xorshift(rng);
			access(4'b0010, 1'b1, rng[7:0], rng[25:8]);
			rom_reads();
		end
		finish_test(2);

		set_cart(MAGIC_DESK);
		for (int s = 0; s < 3; s++) begin
			start_load();
			for (int i = 0; i < sizes[s]; i++)
				load_packet(i, 16'h8000, 16'h2000, 7'(i));
			cart_loading = 1'b0;
			rng = xorshift(rng);
			access(4'b0010, 1'b1, {1'b0, rng[6:0]}, rng[25:8]);
			rom_reads();
			access(4'b0010, 1'b1, {1'b1, rng[14:8]}, rng[25:8]);   // Bit 7 hides the cart
			rom_reads();
		end
		finish_test(3);

		// ******************************
		// EasyFlash and write protection
		// ******************************
		start_load();
		for (int i = 0; i < 16; i++) begin
			rng = xorshift(rng);
			load_packet(i, 16'h8000, 16'h4000, rng[6:0]);
		end
		cart_loading = 1'b0;
		set_cart(EASYFLASH_X);
		repeat (4) begin
			rng = xorshift(rng);
			access(4'b0010, 1'b1, {rng[23:22], 2'b00, rng[27:24]}, {rng[17:2], 2'b00});
			rom_reads();
		end
		repeat (3) begin
			rng = xorshift(rng);
			access(4'b0010, 1'b1, rng[31:24], {rng[17:2], 2'b10});
			rom_reads();
		end
		access(4'b0001, 1'b1, rng[7:0], rng[17:0]);
		access(4'b0001, 1'b0, 8'h00, rng[25:8]);
		set_cart(EASYFLASH);
		rom_reads();
		finish_test(4);

		set_cart(EASYFLASH_X);    // Starts in ultimax
		rng = xorshift(rng);
		access(4'b1000, 1'b1, rng[7:0], rng[25:8]);
		set_cart(OCEAN);
		rom_reads();
		finish_test(5);

		next_cycle();
		$display("Summary: %0d checks, %0d errors, %0d assertion failures", checks, errors,
			DUT.u_check.fails);
		if (errors == 0 && DUT.u_check.fails == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// File: list.f
src/cart_pkg.sv
src/bank_loader.sv
src/bank_table.sv
src/bank_mapper.sv
src/addr_translate.sv
src/cartridge_top.sv
testbench/cartridge_checker.sv
testbench/cart_monitor.sv
testbench/cartridge_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = cartridge_tb
FILELIST = list.f
OBJ_DIR  = obj_dir
SIM_ARGS = +verilator+error+limit+100
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
